/* build.f */
hdl/mmuTlbPkg.sv
hdl/tlbWayStore.sv
hdl/tlbLookup.sv
hdl/tlbBypassDecode.sv
hdl/mmuTlb.sv
verif/mmuTlb_assert.sv
verif/mmuTlbTb.sv

/* hdl/mmuTlb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage TLB between L1 and L2. Leave one idle cycle after
// each request. The 8-bit generation wraps after 256 invalidates.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mmuTlb
	import mmuTlbPkg::*;
(
	input logic clock,
	input logic reset,
	input logic hold,
	input memReqT inReq,
	input logic [ldtlbWidth-1:0] ldtlbData,
	input mmuCtrlT ctrl,
	output memReqT outReq,
	output tlbExcT outExc
);

	memReqT reqReg;
	logic [ldtlbWidth-1:0] ldtlbReg;
	logic [setIndexWidth-1:0] indexReg;
	logic [genWidth-1:0] generation;

	logic inIsLdtlb;
	logic [vaddrWidth-1:0] indexAddr;
	logic [setIndexWidth-1:0] hashSel;
	logic [setIndexWidth-1:0] setIndex;

	logic reqIsLdtlb;
	logic reqIsInvtlb;
	tlbSetT curSet;
	tlbSetT newSet;
	logic hit;
	logic setChange;
	logic translate;
	logic [vaddrWidth-1:0] physAddr;
	memReqT decodedReq;
	tlbExcT decodedExc;

	// a load-entry command indexes by the vpn it carries
	assign inIsLdtlb = (inReq.opm[7:0] == opmLdtlb);
	assign indexAddr = inIsLdtlb ?
		{ldtlbData[ldVpnMsb:ldVpnLsb], {pageShift{1'b0}}} : inReq.addr;

	always_comb
	begin
		if (ctrl.pg64K)
			hashSel = indexAddr[27:22];
		else if (ctrl.pg16K)
			hashSel = {indexAddr[15:14], indexAddr[25:22]};
		else
			hashSel = {indexAddr[15:12], indexAddr[23:22]};
	end

	assign setIndex = hashSel ^ indexAddr[21:16];

	// input stage
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqReg.opm <= '0;
		end
		else if (!hold)
		begin
			reqReg <= inReq;
			ldtlbReg <= ldtlbData;
			indexReg <= setIndex;
		end
	end

	assign reqIsLdtlb = (reqReg.opm[7:0] == opmLdtlb);
	assign reqIsInvtlb = (reqReg.opm[7:0] == opmInvtlb);

	// invalidate retires every entry by moving on a generation
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			generation <= '0;
		end
		else if (!hold && reqIsInvtlb)
		begin
			generation <= generation + 1'b1;
		end
	end

	tlbWayStore tlbWayStore_inst (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.readIndex(setIndex),
		.writeIndex(indexReg),
		.writeSet(newSet),
		.writeEnable(setChange && (translate || reqIsLdtlb)),
		.readSet(curSet)
	);

	tlbLookup tlbLookup_inst (
		.reqAddr(reqReg.addr),
		.isLdtlb(reqIsLdtlb),
		.ldtlbData(ldtlbReg),
		.ctrl(ctrl),
		.generation(generation),
		.curSet(curSet),
		.hit(hit),
		.physAddr(physAddr),
		.newSet(newSet),
		.setChange(setChange)
	);

	tlbBypassDecode tlbBypassDecode_inst (
		.req(reqReg),
		.ctrl(ctrl),
		.hit(hit),
		.physAddr(physAddr),
		.outReq(decodedReq),
		.exc(decodedExc),
		.translate(translate)
	);

	// output stage
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			outReq.opm <= '0;
			outExc.code <= '0;
		end
		else if (!hold)
		begin
			outReq <= decodedReq;
			outExc <= decodedExc;
		end
	end

endmodule

/* hdl/mmuTlbPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLB types and constants. Addresses are always 48-bit, the
// TLB has 64 sets of 4 ways, and a generation tag is 8 bits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mmuTlbPkg;

	// address geometry
	localparam int vaddrWidth = 48;
	localparam int pageShift = 12;
	localparam int vpnWidth = vaddrWidth - pageShift;

	// translation cache geometry
	localparam int setIndexWidth = 6;
	localparam int numSets = 1 << setIndexWidth;
	localparam int genWidth = 8;

	// request fields
	localparam int dataWidth = 128;
	localparam int opmWidth = 16;
	localparam int seqWidth = 16;
	localparam int excCodeWidth = 16;
	localparam int ldtlbWidth = 128;

	// command opcodes, compared against opm[7:0]
	localparam logic [7:0] opmIdle = 8'h00;
	localparam logic [7:0] opmLdtlb = 8'h05;
	localparam logic [7:0] opmInvtlb = 8'h06;

	// access class, compared against opm[7:4]
	localparam logic [3:0] opmLoadClass = 4'h9;
	localparam logic [3:0] opmStoreClass = 4'hA;

	localparam logic [excCodeWidth-1:0] excTlbMiss = 16'hA001;

	// page number sent out on a miss, offset appended below it
	localparam logic [vpnWidth-1:0] missPage = 36'h010;

	// load-entry data word: valid at bit 0, ppn at 47:12, vpn at 111:76
	localparam int ldValidBit = 0;
	localparam int ldPpnLsb = 12;
	localparam int ldPpnMsb = ldPpnLsb + vpnWidth - 1;
	localparam int ldVpnLsb = 76;
	localparam int ldVpnMsb = ldVpnLsb + vpnWidth - 1;

	// request and response on the L1 / L2 side
	typedef struct packed {
		logic [vaddrWidth-1:0] addr;
		logic [dataWidth-1:0] data;
		logic [opmWidth-1:0] opm;
		logic [seqWidth-1:0] seq;
	} memReqT;

	// MMU control, 64K wins when both page bits are set
	typedef struct packed {
		logic enable;
		logic pg16K;
		logic pg64K;
	} mmuCtrlT;

	typedef struct packed {
		logic valid;
		logic [genWidth-1:0] gen;
		logic [vpnWidth-1:0] vpn;
		logic [vpnWidth-1:0] ppn;
	} tlbEntryT;

	// way A is the most recently used
	typedef struct packed {
		tlbEntryT wayA;
		tlbEntryT wayB;
		tlbEntryT wayC;
		tlbEntryT wayD;
	} tlbSetT;

	typedef struct packed {
		logic [excCodeWidth-1:0] code;
		logic [vaddrWidth-1:0] tea;
	} tlbExcT;

endpackage

/* hdl/tlbBypassDecode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Window classification and final request forming. Only
// loads and stores outside the physical and MMIO windows translate.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tlbBypassDecode
	import mmuTlbPkg::*;
(
	input memReqT req,
	input mmuCtrlT ctrl,
	input logic hit,
	input logic [vaddrWidth-1:0] physAddr,
	output memReqT outReq,
	output tlbExcT exc,
	output logic translate
);

	logic [3:0] topNibble;
	logic hi4G;
	logic lo4G;
	logic isPhys;
	logic isPhysD;
	logic isMmio;
	logic isLoadStore;

	assign topNibble = req.addr[vaddrWidth-1 -: 4];
	assign hi4G = (req.addr[47:32] == 16'hFFFF);
	assign lo4G = (req.addr[47:32] == 16'h0000);

	// C and D regions, plus the low half of the top 4G
	assign isPhysD = (topNibble == 4'hD);
	assign isPhys = (topNibble == 4'hC) || isPhysD || (hi4G && !req.addr[31]);

	// F region, or the top 256M of the lowest or highest 4G
	assign isMmio = (topNibble == 4'hF) ||
		((req.addr[31:28] == 4'hF) && (hi4G || lo4G));

	assign isLoadStore = (req.opm[7:4] == opmLoadClass) ||
		(req.opm[7:4] == opmStoreClass);

	assign translate = ctrl.enable && isLoadStore && !isPhys && !isMmio;

	always_comb
	begin
		outReq = req;
		exc.code = '0;
		exc.tea = req.addr;

		if (isPhysD)
		begin
			outReq.opm[11] = 1'b1;
		end

		if (translate)
		begin
			if (hit)
			begin
				outReq.addr = physAddr;
			end
			else
			begin
				// miss goes to a fixed page, offset kept
				outReq.addr = {missPage, req.addr[pageShift-1:0]};
				outReq.opm[11:8] = 4'hF;
				exc.code = excTlbMiss;
			end
		end
		else if (isPhys)
		begin
			outReq.addr[vaddrWidth-1 -: 4] = 4'hC;
			if (hi4G)
			begin
				outReq.addr[43:32] = 12'h000;
			end
		end
	end

endmodule

/* hdl/tlbLookup.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational tag compare and set update. Entries from an
// older generation never hit.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tlbLookup
	import mmuTlbPkg::*;
(
	input logic [vaddrWidth-1:0] reqAddr,
	input logic isLdtlb,
	input logic [ldtlbWidth-1:0] ldtlbData,
	input mmuCtrlT ctrl,
	input logic [genWidth-1:0] generation,
	input tlbSetT curSet,
	output logic hit,
	output logic [vaddrWidth-1:0] physAddr,
	output tlbSetT newSet,
	output logic setChange
);

	tlbEntryT ways [4];
	logic [3:0] wayHit;
	logic [vpnWidth-1:0] reqVpn;
	logic [vpnWidth-1:0] vpnMask;
	logic [vpnWidth-1:0] hitPpn;
	tlbEntryT newEntry;

	assign ways[0] = curSet.wayA;
	assign ways[1] = curSet.wayB;
	assign ways[2] = curSet.wayC;
	assign ways[3] = curSet.wayD;

	assign reqVpn = reqAddr[vaddrWidth-1:pageShift];

	// low vpn bits are page offset for the larger pages
	always_comb
	begin
		vpnMask = '1;
		if (ctrl.pg64K)
		begin
			vpnMask[3:0] = 4'h0;
		end
		else if (ctrl.pg16K)
		begin
			vpnMask[1:0] = 2'h0;
		end
	end

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			wayHit[i] = ways[i].valid && (ways[i].gen == generation) &&
				(((ways[i].vpn ^ reqVpn) & vpnMask) == '0);
		end
	end

	assign hit = |wayHit;

	// way A has priority should two ways match
	always_comb
	begin
		if (wayHit[0])
			hitPpn = curSet.wayA.ppn;
		else if (wayHit[1])
			hitPpn = curSet.wayB.ppn;
		else if (wayHit[2])
			hitPpn = curSet.wayC.ppn;
		else
			hitPpn = curSet.wayD.ppn;
	end

	always_comb
	begin
		physAddr = {hitPpn, reqAddr[pageShift-1:0]};
		if (ctrl.pg16K || ctrl.pg64K)
		begin
			physAddr[13:12] = reqAddr[13:12];
		end
		if (ctrl.pg64K)
		begin
			physAddr[15:14] = reqAddr[15:14];
		end
		// low physical space maps into the C window
		if (physAddr[vaddrWidth-1 -: 4] == 4'h0)
		begin
			physAddr[vaddrWidth-1 -: 4] = 4'hC;
		end
	end

	always_comb
	begin
		newEntry.valid = ldtlbData[ldValidBit];
		newEntry.gen = generation;
		newEntry.vpn = ldtlbData[ldVpnMsb:ldVpnLsb];
		newEntry.ppn = ldtlbData[ldPpnMsb:ldPpnLsb];
	end

	// insert at A or move the hit way to the front
	always_comb
	begin
		newSet = curSet;
		setChange = 1'b0;
		if (isLdtlb)
		begin
			newSet.wayA = newEntry;
			newSet.wayB = curSet.wayA;
			newSet.wayC = curSet.wayB;
			newSet.wayD = curSet.wayC;
			setChange = 1'b1;
		end
		else if (ctrl.enable && !wayHit[0])
		begin
			if (wayHit[1])
			begin
				newSet.wayA = curSet.wayB;
				newSet.wayB = curSet.wayA;
				setChange = 1'b1;
			end
			else if (wayHit[2])
			begin
				newSet.wayA = curSet.wayC;
				newSet.wayB = curSet.wayA;
				newSet.wayC = curSet.wayB;
				setChange = 1'b1;
			end
			else if (wayHit[3])
			begin
				newSet.wayA = curSet.wayD;
				newSet.wayB = curSet.wayA;
				newSet.wayC = curSet.wayB;
				newSet.wayD = curSet.wayC;
				setChange = 1'b1;
			end
		end
	end

endmodule

/* hdl/tlbWayStore.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four way arrays with a registered set read. A write right
// after another write is dropped, so space requests apart.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tlbWayStore
	import mmuTlbPkg::*;
(
	input logic clock,
	input logic reset,
	input logic hold,
	input logic [setIndexWidth-1:0] readIndex,
	input logic [setIndexWidth-1:0] writeIndex,
	input tlbSetT writeSet,
	input logic writeEnable,
	output tlbSetT readSet
);

	tlbEntryT arrA [numSets];
	tlbEntryT arrB [numSets];
	tlbEntryT arrC [numSets];
	tlbEntryT arrD [numSets];

	// set when the previous cycle performed a write
	logic wroteLast;
	logic doWrite;

	// entries start out invalid in simulation
	initial
	begin
		for (int i = 0; i < numSets; i++)
		begin
			arrA[i] = '0;
			arrB[i] = '0;
			arrC[i] = '0;
			arrD[i] = '0;
		end
	end

	// a write following a write was computed from a stale read
	assign doWrite = writeEnable && !hold && !wroteLast;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wroteLast <= 1'b0;
		end
		else if (!hold)
		begin
			wroteLast <= doWrite;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			readSet.wayA <= arrA[readIndex];
			readSet.wayB <= arrB[readIndex];
			readSet.wayC <= arrC[readIndex];
			readSet.wayD <= arrD[readIndex];
		end
	end

	// whole set written at once
	always @(posedge clock)
	begin
		if (doWrite)
		begin
			arrA[writeIndex] <= writeSet.wayA;
			arrB[writeIndex] <= writeSet.wayB;
			arrC[writeIndex] <= writeSet.wayC;
			arrD[writeIndex] <= writeSet.wayD;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mmuTlbTb \
	-f build.f -o simTlb

./obj_dir/simTlb | tee sim.log

grep -q "^TEST OK$" sim.log

/* verif/mmuTlbTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLB testbench. Rows from a table, each followed by one idle
// cycle; ctrl stays fixed for the row and its idle cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mmuTlbTb
	import mmuTlbPkg::*;
();

	localparam logic [1:0] clsHit = 2'd0;
	localparam logic [1:0] clsMiss = 2'd1;
	localparam logic [1:0] clsOther = 2'd2;
	localparam logic [15:0] opLoad = 16'h0091;
	localparam logic [15:0] opStore = 16'h00A2;
	localparam logic [15:0] opLd = {8'h00, opmLdtlb};
	localparam logic [15:0] opInv = {8'h00, opmInvtlb};
	localparam mmuCtrlT ctrl4K = 3'b100;
	localparam mmuCtrlT ctrl16K = 3'b110;
	localparam mmuCtrlT ctrl64K = 3'b101;
	localparam mmuCtrlT ctrlOff = 3'b000;

	// one stimulus row and the access class it should give
	typedef struct packed {
		logic [3:0] testNum;
		logic [15:0] opm;
		logic [47:0] addr;
		logic [127:0] ldData;
		mmuCtrlT ctrl;
		logic [1:0] holdCycles;
		logic [1:0] expectClass;
	} rowT;

	logic clock;
	logic reset;
	logic hold;
	memReqT inReq;
	logic [ldtlbWidth-1:0] ldtlbData;
	mmuCtrlT ctrl;
	memReqT outReq;
	tlbExcT outExc;

	rowT testRows [$];
	tlbEntryT refWays [numSets][4];
	logic [genWidth-1:0] refGen;
	logic [31:0] lfsrState;
	logic rowFailed;
	int checkCount = 0;
	int errorCount = 0;
	int cycleCount = 0;
	int cycleLimit = 1000;

	mmuTlb mmuTlb_inst (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.inReq(inReq),
		.ldtlbData(ldtlbData),
		.ctrl(ctrl),
		.outReq(outReq),
		.outExc(outExc)
	);

	bind mmuTlb mmuTlbAssert mmuTlbAssert_inst (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.outReq(outReq),
		.outExc(outExc)
	);

	always #20 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic logic [47:0] randBits(input int n);
		logic [47:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[46:0], lfsrBit()};
		end
		return v;
	endfunction

	function automatic logic [127:0] makeLd(input logic [35:0] vpn, input logic [35:0] ppn);
		return {16'h0, vpn, 28'h0, ppn, 11'h0, 1'b1};
	endfunction

	function automatic logic [5:0] refIndex(input logic [47:0] a, input mmuCtrlT c);
		logic [5:0] sel;
		if (c.pg64K)
			sel = a[27:22];
		else if (c.pg16K)
			sel = {a[15:14], a[25:22]};
		else
			sel = {a[15:12], a[23:22]};
		return sel ^ a[21:16];
	endfunction

	// in-page offset bits for the page size
	function automatic logic [47:0] offsetMask(input mmuCtrlT c);
		if (c.pg64K)
			return 48'hFFFF;
		else if (c.pg16K)
			return 48'h3FFF;
		return 48'h0FFF;
	endfunction

	task automatic addRow(input logic [3:0] testNum, input logic [15:0] opm,
		input logic [47:0] addr, input logic [127:0] ldData, input mmuCtrlT c,
		input logic [1:0] holdCycles, input logic [1:0] expectClass);
		testRows.push_back('{testNum, opm, addr, ldData, c, holdCycles, expectClass});
	endtask

	task automatic checkValue(input string what, input logic [255:0] got,
		input logic [255:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			rowFailed = 1'b1;
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got,
				expected);
		end
	endtask

	// reference model: expected response, then the TLB state update
	task automatic modelRow(input memReqT req, input logic [127:0] ld, input mmuCtrlT c,
		output memReqT expReq, output tlbExcT expExc, output logic [1:0] cls);
		logic [47:0] a;
		logic [47:0] pm;
		logic [47:0] pa;
		logic [5:0] idx;
		logic hi4G;
		logic lo4G;
		logic isPhys;
		logic isMmio;
		logic xlate;
		int hitWay;
		tlbEntryT e;
		a = req.addr;
		hi4G = (a[47:32] == 16'hFFFF);
		lo4G = (a[47:32] == 16'h0000);
		isPhys = (a[47:44] == 4'hC) || (a[47:44] == 4'hD) || (hi4G && !a[31]);
		isMmio = (a[47:44] == 4'hF) || ((a[31:28] == 4'hF) && (hi4G || lo4G));
		xlate = c.enable && !isPhys && !isMmio &&
			((req.opm[7:4] == opmLoadClass) || (req.opm[7:4] == opmStoreClass));
		expReq = req;
		expExc.code = '0;
		expExc.tea = a;
		cls = clsOther;
		if (a[47:44] == 4'hD)
			expReq.opm[11] = 1'b1;
		if (xlate)
		begin
			idx = refIndex(a, c);
			pm = offsetMask(c);
			hitWay = -1;
			for (int w = 3; w >= 0; w--)
			begin
				e = refWays[idx][w];
				if (e.valid && (e.gen == refGen) && (((e.vpn ^ a[47:12]) & ~pm[47:12]) == '0))
					hitWay = w;
			end
			if (hitWay >= 0)
			begin
				cls = clsHit;
				e = refWays[idx][hitWay];
				pa = ({e.ppn, 12'h000} & ~pm) | (a & pm);
				if (pa[47:44] == 4'h0)
					pa[47:44] = 4'hC;
				expReq.addr = pa;
				// hit way to the front
				for (int w = hitWay; w > 0; w--)
				begin
					refWays[idx][w] = refWays[idx][w-1];
				end
				refWays[idx][0] = e;
			end
			else
			begin
				cls = clsMiss;
				expReq.addr = {missPage, a[11:0]};
				expReq.opm[11:8] = 4'hF;
				expExc.code = excTlbMiss;
			end
		end
		else if (isPhys)
		begin
			expReq.addr[47:44] = 4'hC;
			if (hi4G)
				expReq.addr[43:32] = 12'h000;
		end
		if (req.opm[7:0] == opmLdtlb)
		begin
			idx = refIndex({ld[111:76], 12'h000}, c);
			for (int w = 3; w > 0; w--)
			begin
				refWays[idx][w] = refWays[idx][w-1];
			end
			e.valid = ld[0];
			e.gen = refGen;
			e.vpn = ld[111:76];
			e.ppn = ld[47:12];
			refWays[idx][0] = e;
		end
		if (req.opm[7:0] == opmInvtlb)
			refGen = refGen + 8'd1;
	endtask

	task automatic buildTable();
		logic [35:0] vpn;
		logic [35:0] ppn;
		logic [35:0] keepVpn;
		logic [35:0] setVpn [6];
		logic [35:0] setPpn [6];
		// load then access, one pair per page size
		vpn = {4'h1, 32'(randBits(32))};
		ppn = {4'h0, 32'(randBits(32))};
		keepVpn = vpn;
		addRow(1, opLd, '0, makeLd(vpn, ppn), ctrl4K, 0, clsOther);
		addRow(1, opLoad, {vpn, 12'(randBits(12))}, '0, ctrl4K, 0, clsHit);
		vpn = {4'h1, 32'(randBits(32))};
		ppn = {4'h3, 32'(randBits(32))};
		addRow(1, opLd, '0, makeLd(vpn, ppn), ctrl16K, 0, clsOther);
		addRow(1, opStore, {vpn[35:2], 14'(randBits(14))}, '0, ctrl16K, 0, clsHit);
		vpn = {4'h1, 32'(randBits(32))};
		ppn = {4'h0, 32'(randBits(32))};
		addRow(1, opLd, '0, makeLd(vpn, ppn), ctrl64K, 0, clsOther);
		addRow(1, opLoad, {vpn[35:4], 16'(randBits(16))}, '0, ctrl64K, 0, clsHit);
		// never loaded
		addRow(2, opLoad, {4'h5, 44'(randBits(44))}, '0, ctrl4K, 0, clsMiss);
		addRow(2, opStore, {4'h6, 44'(randBits(44))}, '0, ctrl4K, 0, clsMiss);
		// same set, pages differ only above the hashed bits
		vpn = {4'h2, 32'(randBits(32))};
		for (int i = 0; i < 6; i++)
		begin
			setVpn[i] = vpn ^ (36'(i) << 20);
			setPpn[i] = {4'h0, 32'(randBits(32))};
		end
		for (int i = 0; i < 5; i++)
		begin
			addRow(3, opLd, '0, makeLd(setVpn[i], setPpn[i]), ctrl4K, 0, clsOther);
		end
		addRow(3, opLoad, {setVpn[0], 12'(randBits(12))}, '0, ctrl4K, 0, clsMiss);
		addRow(3, opLoad, {setVpn[1], 12'(randBits(12))}, '0, ctrl4K, 0, clsHit);
		addRow(3, opLd, '0, makeLd(setVpn[5], setPpn[5]), ctrl4K, 0, clsOther);
		addRow(3, opStore, {setVpn[1], 12'(randBits(12))}, '0, ctrl4K, 0, clsHit);
		addRow(3, opLoad, {setVpn[2], 12'(randBits(12))}, '0, ctrl4K, 0, clsMiss);
		// invalidate, then reload one page
		addRow(4, opInv, '0, '0, ctrl4K, 0, clsOther);
		addRow(4, opLoad, {keepVpn, 12'(randBits(12))}, '0, ctrl4K, 0, clsMiss);
		addRow(4, opLoad, {setVpn[1], 12'(randBits(12))}, '0, ctrl4K, 0, clsMiss);
		addRow(4, opLd, '0, makeLd(setVpn[1], setPpn[1]), ctrl4K, 0, clsOther);
		addRow(4, opLoad, {setVpn[1], 12'(randBits(12))}, '0, ctrl4K, 0, clsHit);
		// physical, MMIO and MMU off
		addRow(5, opLoad, 48'hC000_1234_5678, '0, ctrl4K, 0, clsOther);
		addRow(5, opStore, 48'hD000_0ABC_0000, '0, ctrl4K, 0, clsOther);
		addRow(5, opLoad, 48'hFFFF_1234_5678, '0, ctrl4K, 0, clsOther);
		addRow(5, opLoad, 48'hFFFF_F000_0010, '0, ctrl4K, 0, clsOther);
		addRow(5, opStore, 48'h0000_F000_0020, '0, ctrl4K, 0, clsOther);
		addRow(5, opLoad, 48'hF123_4567_8000, '0, ctrl4K, 0, clsOther);
		addRow(5, opLoad, {4'h1, 44'(randBits(44))}, '0, ctrlOff, 0, clsOther);
		addRow(5, opStore, 48'hD123_4567_8000, '0, ctrlOff, 0, clsOther);
		// three held cycles mid-request
		addRow(6, opLoad, {setVpn[1], 12'(randBits(12))}, '0, ctrl4K, 3, clsHit);
		addRow(6, opStore, {4'h7, 44'(randBits(44))}, '0, ctrl4K, 3, clsMiss);
	endtask

	initial
	begin
		rowT r;
		memReqT req;
		memReqT idleReq;
		memReqT expReq;
		tlbExcT expExc;
		memReqT heldReq;
		tlbExcT heldExc;
		logic [1:0] cls;
		clock = 1'b0;
		reset = 1'b1;
		hold = 1'b0;
		inReq = '0;
		ldtlbData = '0;
		ctrl = '0;
		idleReq = '0;
		idleReq.seq = 16'hFFFF;
		lfsrState = 32'h43f20bfd;
		refGen = '0;
		for (int s = 0; s < numSets; s++)
		begin
			for (int w = 0; w < 4; w++)
			begin
				refWays[s][w] = '0;
			end
		end
		buildTable();
		// two cycles a row, hold cycles on top, then slack
		cycleLimit = 4 * testRows.size() + 50;

		repeat (5) @(posedge clock);
		#2;
		reset = 1'b0;

		for (int i = 0; i < testRows.size(); i++)
		begin
			r = testRows[i];
			rowFailed = 1'b0;
			req.addr = r.addr;
			req.data = {4{32'h5A000000 + 32'(i)}};
			req.opm = r.opm;
			req.seq = 16'(i);
			inReq = req;
			ldtlbData = r.ldData;
			ctrl = r.ctrl;
			modelRow(req, r.ldData, r.ctrl, expReq, expExc, cls);
			@(posedge clock);
			#2;
			inReq = idleReq;
			ldtlbData = '0;
			if (r.holdCycles != 0)
			begin
				hold = 1'b1;
				// the idle request before this row passes through unchanged
				heldReq = idleReq;
				heldExc = '0;
				repeat (r.holdCycles)
				begin
					@(posedge clock);
					#2;
					checkValue("held outReq", outReq, heldReq);
					checkValue("held outExc", outExc, heldExc);
				end
				hold = 1'b0;
			end
			@(posedge clock);
			#2;
			checkValue("outReq.addr", outReq.addr, expReq.addr);
			checkValue("outReq.data", outReq.data, expReq.data);
			checkValue("outReq.opm", outReq.opm, expReq.opm);
			checkValue("outReq.seq", outReq.seq, expReq.seq);
			checkValue("outExc.code", outExc.code, expExc.code);
			if (expExc.code == excTlbMiss)
				checkValue("outExc.tea", outExc.tea, expExc.tea);
			checkValue("access class", cls, r.expectClass);
			$display("row %0d (test %0d) %s", i, r.testNum, rowFailed ? "failed" : "passed");
		end

		$display("%0d rows, %0d checks, %0d mismatches", testRows.size(), checkCount,
			errorCount);
		if (errorCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* verif/mmuTlb_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checks on the TLB outputs, bound into mmuTlb. Only the
// reset value, the exception code and hold stability.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mmuTlbAssert
	import mmuTlbPkg::*;
(
	input logic clock,
	input logic reset,
	input logic hold,
	input memReqT outReq,
	input tlbExcT outExc
);

	// output opcode cleared by every reset cycle
	opmClearedAfterReset: assert property (@(posedge clock)
		reset |=> (outReq.opm == '0))
		else $error("outReq.opm is not zero after reset");

	// only the miss exception exists, and it rides on a miss request
	excCodeKnown: assert property (@(posedge clock) disable iff (reset)
		!hold |-> ((outExc.code == '0) ||
			((outExc.code == excTlbMiss) && (outReq.opm[11:8] == 4'hF) &&
			(outReq.addr[vaddrWidth-1:pageShift] == missPage) &&
			(outExc.tea[pageShift-1:0] == outReq.addr[pageShift-1:0]))))
		else $error("outExc.code is unknown or does not match the miss request");

	stableWhileHeld: assert property (@(posedge clock) disable iff (reset)
		hold |=> ($stable(outReq) && $stable(outExc)))
		else $error("outputs changed while hold was high");

endmodule
